/* design/joy_pkg.sv */
// shared constants for the two-port DB9 reader; assumes two 74HC165 parts and Sega 3/6 button pads.
`default_nettype none

package joy_pkg;

    localparam int joy_clk_div    = 4;  // clk cycles per joy_clk half period.
    localparam int joy_frame_bits = 16; // one 8-bit field per port.

    // where each port field sits inside the serial frame.
    localparam int port1_base = 8;      // frame bits 15..8.
    localparam int port2_base = 0;      // frame bits 7..0.
    localparam int port_field_w = 8;

    // pin places inside an 8-bit port field.
    localparam int fld_up    = 7;
    localparam int fld_down  = 6;
    localparam int fld_left  = 5;
    localparam int fld_right = 4;
    localparam int fld_p6    = 3;
    localparam int fld_p9    = 2;       // bits 1..0 are spare.

    // places inside the 6-bit pin snapshot.
    localparam int pin_up    = 5;
    localparam int pin_down  = 4;
    localparam int pin_left  = 3;
    localparam int pin_right = 2;
    localparam int pin_p6    = 1;
    localparam int pin_p9    = 0;

    // select sequence.
    localparam int sega_phases     = 8;  // hs-timed phases per scan.
    localparam int sega_idle_lines = 16; // hs pulses with select parked high.
    localparam int sega_phase_w    = $clog2(sega_phases);
    localparam int sega_idle_w     = $clog2(sega_idle_lines);

    localparam logic [sega_phase_w-1:0] ph_dir_bc   = sega_phase_w'(0); // udlr, b on p6, c on p9.
    localparam logic [sega_phase_w-1:0] ph_a_start  = sega_phase_w'(1); // a on p6, start on p9.
    localparam logic [sega_phase_w-1:0] ph_six_id   = sega_phase_w'(5); // udlr all low on 6-button.
    localparam logic [sega_phase_w-1:0] ph_xyz_mode = sega_phase_w'(6); // z y x mode on udlr.

    // raw active-low word layout.
    localparam int raw_mode  = 11;
    localparam int raw_x     = 10;
    localparam int raw_y     = 9;
    localparam int raw_z     = 8;
    localparam int raw_start = 7;
    localparam int raw_a     = 6;
    localparam int raw_c     = 5;
    localparam int raw_b     = 4;
    localparam int raw_up    = 3;
    localparam int raw_down  = 2;
    localparam int raw_left  = 1;
    localparam int raw_right = 0;

    // active high output: mode start x y z c b a up down left right.
    function automatic logic [11:0] to_player_word(input logic [11:0] raw);
        return ~{raw[raw_mode], raw[raw_start],
                 raw[raw_x], raw[raw_y], raw[raw_z],
                 raw[raw_c], raw[raw_b], raw[raw_a],
                 raw[raw_up], raw[raw_down], raw[raw_left], raw[raw_right]};
    endfunction

endpackage

`default_nettype wire

/* design/joy_serial_reader.sv */
// reads the 16-bit 74HC165 chain back to back; joy_data must be stable by the end of each low half.
`default_nettype none

module joy_serial_reader
    import joy_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       joy_data,
    output logic       joy_clk,
    output logic       joy_load,     // active low parallel load.
    output logic [5:0] port1_pins,   // up down left right p6 p9, active low.
    output logic [5:0] port2_pins
);

    localparam int div_w = (joy_clk_div > 1) ? $clog2(joy_clk_div) : 1;
    localparam int bit_w = $clog2(joy_frame_bits);
    localparam logic [div_w-1:0] div_last = div_w'(joy_clk_div - 1);
    localparam logic [bit_w-1:0] bit_last = bit_w'(joy_frame_bits - 1);

    typedef enum logic [1:0] {
        st_idle,                     // short gap after reset.
        st_load,                     // one joy_clk period with load low.
        st_shift                     // sixteen joy_clk periods.
    } state_t;

    state_t                    state, state_nx;
    logic [div_w-1:0]          div_cnt;
    logic                      half, half_nx;        // 0 low half, 1 high half.
    logic [bit_w-1:0]          bit_cnt, bit_cnt_nx;  // shift period index.
    logic                      tick;
    logic                      sample;
    logic                      frame_done;
    logic [joy_frame_bits-1:0] shift_q;

    // picks the six used pins out of one port field.
    function automatic logic [5:0] split_port(input logic [port_field_w-1:0] field);
        return {field[fld_up], field[fld_down], field[fld_left],
                field[fld_right], field[fld_p6], field[fld_p9]};
    endfunction

    assign tick   = div_cnt == div_last;                         // end of a half period.
    assign sample = tick && (state == st_shift) && !half;        // last clk of the low half.

    always_comb begin
        state_nx   = state;
        half_nx    = half;
        bit_cnt_nx = bit_cnt;
        if (tick) begin
            case (state)
                st_idle: begin
                    state_nx = st_load;
                    half_nx  = 1'b0;
                end
                st_load: begin
                    half_nx = !half;
                    if (half) begin                              // load period over.
                        state_nx   = st_shift;
                        bit_cnt_nx = '0;
                    end
                end
                default: begin
                    half_nx = !half;
                    if (half) begin
                        if (bit_cnt == bit_last) begin
                            state_nx = st_load;                  // next frame right away.
                        end else begin
                            bit_cnt_nx = bit_cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            half     <= 1'b0;
            bit_cnt  <= '0;
            div_cnt  <= '0;
            joy_load <= 1'b1;
            joy_clk  <= 1'b0;
        end else begin
            state    <= state_nx;
            half     <= half_nx;
            bit_cnt  <= bit_cnt_nx;
            div_cnt  <= tick ? '0 : div_cnt + 1'b1;
            joy_load <= state_nx != st_load;                     // registered, no glitches.
            joy_clk  <= (state_nx == st_shift) && half_nx;       // rises with the sample.
        end
    end

    // frame bit 15 arrives first and ends up on top.
    always_ff @(posedge clk) begin
        if (sample) begin
            shift_q <= {shift_q[joy_frame_bits-2:0], joy_data};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame_done <= 1'b0;
            port1_pins <= '1;                                    // released.
            port2_pins <= '1;
        end else begin
            frame_done <= sample && (bit_cnt == bit_last);       // 16th sample taken.
            if (frame_done) begin
                port1_pins <= split_port(shift_q[port1_base +: port_field_w]);
                port2_pins <= split_port(shift_q[port2_base +: port_field_w]);
            end
        end
    end

endmodule

`default_nettype wire

/* design/neptuno_joy.sv */
// two DB9 Sega pads behind one 74HC165 chain; no mouse, paddle or autofire, select shared.
`default_nettype none

module neptuno_joy
    import joy_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        joy_data,    // serial out of the chain.
    input  logic        hs,          // one select step per pulse.
    output logic        joy_clk,
    output logic        joy_load,    // active low.
    output logic        select,      // shared by both pads.
    output logic [11:0] joy1,        // active high, mode start x y z c b a up down left right.
    output logic [11:0] joy2
);

    logic [5:0]  port1_pins;         // active low pin levels.
    logic [5:0]  port2_pins;
    logic [11:0] raw1;               // active low scanner words.
    logic [11:0] raw2;

    // chain clocking and pin snapshot.
    joy_serial_reader joy_serial_reader_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .joy_data   (joy_data),
        .joy_clk    (joy_clk),
        .joy_load   (joy_load),
        .port1_pins (port1_pins),
        .port2_pins (port2_pins)
    );

    // select sequencing and button assembly.
    sega_pad_scanner sega_pad_scanner_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .hs         (hs),
        .port1_pins (port1_pins),
        .port2_pins (port2_pins),
        .select     (select),
        .raw1       (raw1),
        .raw2       (raw2)
    );

    // reorder and invert.
    assign joy1 = to_player_word(raw1);   // player 1 on the upper frame field.
    assign joy2 = to_player_word(raw2);

endmodule

`default_nettype wire

/* design/sega_pad_scanner.sv */
// steps select once per hs pulse; hs pulses must be at least two serial frames apart.
`default_nettype none

module sega_pad_scanner
    import joy_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        hs,
    input  logic [5:0]  port1_pins,   // active low snapshot from the reader.
    input  logic [5:0]  port2_pins,
    output logic        select,
    output logic [11:0] raw1,         // active low, mode x y z start a c b udlr.
    output logic [11:0] raw2
);

    localparam logic [sega_phase_w-1:0] last_phase = sega_phase_w'(sega_phases - 1);
    localparam logic [sega_idle_w-1:0]  last_idle  = sega_idle_w'(sega_idle_lines - 1);
    localparam logic [11:0] ext_mask = (12'b1 << raw_mode) | (12'b1 << raw_x) |
                                       (12'b1 << raw_y) | (12'b1 << raw_z);

    logic                    hs_meta;
    logic                    hs_sync;
    logic                    hs_last;
    logic                    hs_rise;
    logic [sega_phase_w-1:0] phase;
    logic                    in_idle;        // select parked high between scans.
    logic [sega_idle_w-1:0]  idle_cnt;
    logic [11:0]             pend1, pend2;   // words being built this scan.
    logic                    six1, six2;     // six-button pad seen.

    // stores the pins that the current phase carries.
    function automatic logic [11:0] capture_phase(input logic [11:0]             word,
                                                  input logic [5:0]              pins,
                                                  input logic [sega_phase_w-1:0] ph);
        logic [11:0] w;
        w = word;
        case (ph)
            ph_dir_bc: begin
                w[raw_up]    = pins[pin_up];
                w[raw_down]  = pins[pin_down];
                w[raw_left]  = pins[pin_left];
                w[raw_right] = pins[pin_right];
                w[raw_b]     = pins[pin_p6];
                w[raw_c]     = pins[pin_p9];
            end
            ph_a_start: begin
                w[raw_a]     = pins[pin_p6];
                w[raw_start] = pins[pin_p9];
            end
            ph_xyz_mode: begin
                w[raw_z]     = pins[pin_up];
                w[raw_y]     = pins[pin_down];
                w[raw_x]     = pins[pin_left];
                w[raw_mode]  = pins[pin_right];
            end
            default: begin
                w = word;                            // nothing read in this phase.
            end
        endcase
        return w;
    endfunction

    // 6-button pads pull all four directions low in phase 5.
    function automatic logic six_found(input logic [5:0] pins);
        return ~|{pins[pin_up], pins[pin_down], pins[pin_left], pins[pin_right]};
    endfunction

    // releases the extra buttons of a 3-button pad.
    function automatic logic [11:0] finish_word(input logic [11:0] word, input logic six);
        return six ? word : (word | ext_mask);
    endfunction

    assign hs_rise = hs_sync && !hs_last;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hs_meta <= 1'b0;
            hs_sync <= 1'b0;
            hs_last <= 1'b0;
        end else begin
            hs_meta <= hs;                           // hs comes from another clock.
            hs_sync <= hs_meta;
            hs_last <= hs_sync;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase    <= '0;
            in_idle  <= 1'b0;
            idle_cnt <= '0;
            select   <= 1'b1;
            raw1     <= '1;
            raw2     <= '1;
        end else if (hs_rise) begin
            if (!in_idle) begin
                if (phase == last_phase) begin
                    in_idle  <= 1'b1;
                    idle_cnt <= '0;
                    select   <= 1'b1;                // pads time out while high.
                end else begin
                    phase  <= phase + 1'b1;
                    select <= phase[0];              // even phases high.
                end
            end else if (idle_cnt == last_idle) begin
                in_idle <= 1'b0;
                phase   <= '0;
                raw1    <= finish_word(pend1, six1); // both ports at once.
                raw2    <= finish_word(pend2, six2);
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    // same capture for both ports.
    always_ff @(posedge clk) begin
        if (hs_rise && !in_idle) begin
            pend1 <= capture_phase(pend1, port1_pins, phase);
            pend2 <= capture_phase(pend2, port2_pins, phase);
            if (phase == ph_six_id) begin
                six1 <= six_found(port1_pins);
                six2 <= six_found(port2_pins);
            end
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
    --top-module tb_neptuno_joy -Mdir obj_dir -o sim_neptuno_joy
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_neptuno_joy)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi

/* testbench/joy_cases.txt */
# columns in hex: six1 press1 six2 press2 joy1 joy2
# press and joy bits: mode start x y z c b a up down left right
0 000 0 000 000 000
0 008 0 000 008 000
0 004 0 000 004 000
0 002 0 001 002 001
0 010 0 020 010 020
0 040 0 400 040 400
0 b80 0 000 000 000
0 000 0 b80 000 000
1 200 1 100 200 100
1 080 1 800 080 800
1 fff 0 000 fff 000
0 000 1 fff 000 fff
1 fff 1 fff fff fff
0 47b 1 000 47b 000
1 a5a 0 5a1 a5a 421
1 00c 0 0f0 00c 070

/* testbench/tb_clock_gen.sv */
// free running 10 ns clock; reset held low for three rising edges and released on a falling edge.
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period  = 5;   // ns.
    localparam int reset_cycles = 3;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);                // away from the active edge.
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/tb_neptuno_joy.sv */
// needs testbench/joy_cases.txt relative to the run directory; each case takes about two scans.
`default_nettype none

module tb_neptuno_joy;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int    hs_spacing    = 300;             // clk cycles between hs pulses.
    localparam int    idle_high_min = 4 * hs_spacing;  // longer high means select idled.
    localparam int    scan_timeout  = 16000;           // a scan is 24 hs periods.
    localparam int    random_cases  = 32;
    localparam string case_file     = "testbench/joy_cases.txt";

    logic        clk, arst_n;
    logic        joy_data, hs;
    logic        joy_clk, joy_load, select;
    logic [11:0] joy1, joy2;
    logic        six1 = 1'b0;
    logic        six2 = 1'b0;
    logic [11:0] press1 = '0;
    logic [11:0] press2 = '0;
    logic        frame_err;
    logic [31:0] rng_state;
    int          case_count = 0;

    tb_clock_gen tb_clock_gen_i (.clk(clk), .arst_n(arst_n));

    tb_pad_model tb_pad_model_i (
        .joy_clk (joy_clk),  .joy_load (joy_load), .select (select), .hs (hs),
        .six1    (six1),     .press1   (press1),   .six2   (six2),   .press2 (press2),
        .joy_data(joy_data), .frame_err(frame_err)
    );

    neptuno_joy neptuno_joy_i (
        .clk     (clk),      .arst_n  (arst_n),   .joy_data (joy_data), .hs (hs),
        .joy_clk (joy_clk),  .joy_load(joy_load), .select   (select),
        .joy1    (joy1),     .joy2    (joy2)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [11:0] got,
                               input logic [11:0] expected);
        if (got !== expected) begin
            $display("ERROR %s got %h expected %h", name, got, expected);
            abort_run("output mismatch");
        end
    endtask

    // pressed buttons that a pad of this type can report.
    function automatic logic [11:0] expected_word(input logic six, input logic [11:0] p);
        return six ? p : (p & 12'h47f);                  // no mode x y z on 3 buttons.
    endfunction

    // up with down on a 3-button pad would mimic the 6-button id.
    function automatic logic [11:0] legal_mask(input logic six, input logic [11:0] p);
        return (!six && p[3]) ? (p & 12'hffb) : p;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (arst_n !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > 20) abort_run("timeout: reset was never released");
        end
    endtask

    // select falling after a long high marks phase 0 of a new scan.
    task automatic wait_scan_start();
        int high_cycles;
        int waited;
        bit found;
        high_cycles = 0;
        waited      = 0;
        found       = 1'b0;
        while (!found) begin
            @(negedge clk);
            waited++;
            if (waited > scan_timeout) abort_run("timeout: no new select scan started");
            if (select) begin
                high_cycles++;
            end else begin
                found       = high_cycles >= idle_high_min;
                high_cycles = 0;
            end
        end
    endtask

    // first scan start may be mixed, the next one reports a whole new scan.
    task automatic run_case(input logic t1, input logic [11:0] m1, input logic t2,
                            input logic [11:0] m2, input logic [11:0] e1, input logic [11:0] e2);
        six1   = t1;
        press1 = m1;
        six2   = t2;
        press2 = m2;
        wait_scan_start();
        wait_scan_start();
        check_value("joy1", joy1, e1);
        check_value("joy2", joy2, e2);
        case_count++;
    endtask

    task automatic run_file_cases();
        int          fd;
        int          fields;
        int          lines;
        string       line;
        logic [31:0] t1, m1, t2, m2, e1, e2;
        lines = 0;
        fd    = $fopen(case_file, "r");
        if (fd == 0) abort_run("could not open the case file");
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line.getc(0) == "#") continue;   // blank or comment.
            fields = $sscanf(line, "%h %h %h %h %h %h", t1, m1, t2, m2, e1, e2);
            if (fields != 6) abort_run("case file line does not hold six fields");
            if (e1[11:0] !== expected_word(t1[0], m1[11:0]) ||
                e2[11:0] !== expected_word(t2[0], m2[11:0])) begin
                abort_run("case file expected value does not follow from its masks");
            end
            run_case(t1[0], m1[11:0], t2[0], m2[11:0], e1[11:0], e2[11:0]);
            lines++;
        end
        $fclose(fd);
        if (lines == 0) abort_run("case file holds no cases");
    endtask

    task automatic run_random_cases();
        logic [31:0] r;
        logic        t1, t2;
        logic [11:0] m1, m2;
        for (int i = 0; i < random_cases; i++) begin
            rng_state = xorshift32(rng_state);
            r  = rng_state;
            t1 = r[12];
            t2 = r[28];
            m1 = legal_mask(t1, r[11:0]);
            m2 = legal_mask(t2, r[27:16]);
            run_case(t1, m1, t2, m2, expected_word(t1, m1), expected_word(t2, m2));
        end
    endtask

    // one-clock hs pulse every 300 clocks, well over two serial frames.
    initial begin
        hs = 1'b0;
        forever begin
            repeat (hs_spacing - 1) @(negedge clk);
            hs = 1'b1;
            @(negedge clk);
            hs = 1'b0;
        end
    end

    always @(posedge frame_err) begin
        abort_run("serial frame format check failed");
    end

    initial begin
        rng_state = 32'h9f2e1dc3;
        wait_reset_release();
        check_value("joy1", joy1, 12'h000);              // reset state.
        check_value("joy2", joy2, 12'h000);
        check_value("joy_load", {11'b0, joy_load}, 12'h001);
        check_value("select", {11'b0, select}, 12'h001);
        check_value("joy_clk", {11'b0, joy_clk}, 12'h000);
        run_file_cases();
        run_random_cases();
        $display("%0d cases checked", case_count);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_pad_model.sv */
// two 74HC165 parts and two Sega pads sharing select; pads time out after 3 hs pulses with select high.
`default_nettype none

module tb_pad_model (
    input  logic        joy_clk,
    input  logic        joy_load,    // active low parallel load.
    input  logic        select,
    input  logic        hs,
    input  logic        six1,        // port 1 pad is a 6-button type.
    input  logic [11:0] press1,      // pressed buttons, output word order.
    input  logic        six2,
    input  logic [11:0] press2,
    output logic        joy_data,
    output logic        frame_err    // frame did not hold 16 clocks.
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0] chain = '1;         // port 1 field on top.
    logic [15:0] frame;
    int          falls = 0;          // select falling edges since pad timeout.
    int          high_lines = 0;     // hs pulses seen with select high.
    int          rises = 0;          // joy_clk rises since the last load.
    bit          loaded = 1'b0;

    // pin levels of one pad in its current select state, 8-bit port field.
    function automatic logic [7:0] port_field(input logic six, input logic [11:0] p,
                                              input logic sel, input int f);
        logic [5:0] low_pins;        // 1 pulls the pin low: up down left right p6 p9.
        if (sel) begin
            if (six && f == 3) begin
                low_pins = {p[7], p[8], p[9], p[11], p[5], p[6]}; // z y x mode, b c.
            end else begin
                low_pins = {p[3], p[2], p[1], p[0], p[5], p[6]};  // dirs, b c.
            end
        end else if (six && f == 3) begin
            low_pins = {4'b1111, p[4], p[10]};                    // id state.
        end else if (six && f == 4) begin
            low_pins = {4'b0000, p[4], p[10]};
        end else begin
            low_pins = {p[3], p[2], 2'b11, p[4], p[10]};          // left right grounded.
        end
        return ~{low_pins, 2'b00};                                // spare bits float high.
    endfunction

    assign frame    = {port_field(six1, press1, select, falls),
                       port_field(six2, press2, select, falls)};
    assign joy_data = chain[15];

    initial frame_err = 1'b0;

    // pad counters, hs rises while select is low never count.
    always @(posedge hs or negedge select) begin
        if (hs) begin
            if (select) begin
                high_lines = high_lines + 1;
                if (high_lines > 3) begin
                    falls = 0;                                    // pad timed out.
                end
            end
        end else begin
            falls      = falls + 1;
            high_lines = 0;
        end
    end

    // shift chain, parallel load on the falling load edge.
    always @(posedge joy_clk or negedge joy_load) begin
        if (!joy_load) begin
            if (loaded && rises != 16) begin
                $display("pad model saw %0d joy_clk rises between two loads instead of 16",
                         rises);
                frame_err <= 1'b1;
            end
            loaded <= 1'b1;
            rises  <= 0;
            chain  <= frame;
        end else begin
            rises <= rises + 1;
            chain <= {chain[14:0], 1'b1};                         // serial in tied high.
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
design/joy_pkg.sv
design/joy_serial_reader.sv
design/sega_pad_scanner.sv
design/neptuno_joy.sv
testbench/tb_clock_gen.sv
testbench/tb_pad_model.sv
testbench/tb_neptuno_joy.sv
